// ==== dnn_accelerator_core.f ====
verilog/dnn_geom_pkg.sv
verilog/dnn_mem_pkg.sv
verilog/data_req.sv
verilog/bram_rd_ctrl.sv
verilog/pixel_concat.sv
verilog/line_psum_accum.sv
verilog/psum_bank_writer.sv
verilog/dnn_accelerator_core.sv
bench/dnn_accelerator_core_props.sv
bench/tb_dnn_accelerator_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_dnn_accelerator_core \
    -f dnn_accelerator_core.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// ==== bench/tb_dnn_accelerator_core.sv ====
`timescale 1ns/100ps

module tb_dnn_accelerator_core;

    import dnn_geom_pkg::*;
    import dnn_mem_pkg::*;

    typedef struct packed {
        logic [1:0] bank;
        word_addr_t addr;
        mem_word_t  data;
    } wr_exp_t;

    logic                  clk = 1'b0;
    logic                  i_arst_n;
    logic                  i_start;
    dim_t                  i_conf_width;
    dim_t                  i_conf_height;
    dim_t                  i_conf_kernel_h;
    logic [ADDR_WIDTH-1:0] o_mem_addr_0;
    logic                  o_mem_enb_0;
    logic                  o_mem_rst_0;
    mem_word_t             i_mem_odat_0;
    logic [ADDR_WIDTH-1:0] o_mem_addr_1;
    mem_word_t             o_mem_idat_1;
    logic [NUM_BYTE-1:0]   o_mem_wren_1;
    logic                  o_mem_enb_1;
    logic [ADDR_WIDTH-1:0] o_mem_addr_2;
    mem_word_t             o_mem_idat_2;
    logic [NUM_BYTE-1:0]   o_mem_wren_2;
    logic                  o_mem_enb_2;
    logic                  o_busy;
    logic                  o_done;

    mem_word_t             mem [64];
    logic [5:0]            mem_idx;
    logic [31:0]           lcg_state;
    word_addr_t            rd_q [$];
    wr_exp_t               wr_q [$];
    word_addr_t            exp_rd;
    wr_exp_t               exp_wr;
    word_addr_t            act_addr;
    mem_word_t             act_dat;
    logic [NUM_BYTE-1:0]   act_wren;
    int                    port;
    int                    cyc = 0;
    int                    last_wr_cyc = -10;
    int                    done_cnt = 0;
    int                    mismatch_cnt = 0;
    int                    order_cnt = 0;
    int                    props_fails;

    dnn_accelerator_core dut_i (.*);

    bind dnn_accelerator_core dnn_accelerator_core_props props_i (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_start    (i_start),
        .i_busy     (o_busy),
        .i_done     (o_done),
        .i_rd_enb   (o_mem_enb_0),
        .i_wr_enb_1 (o_mem_enb_1),
        .i_wr_enb_2 (o_mem_enb_2),
        .i_wren_1   (o_mem_wren_1),
        .i_wren_2   (o_mem_wren_2)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int run_words(input int w, input int h, input int k);
        return (h - k + 1) * k * (w * 3 / 4);
    endfunction

    // Channel sum of pixel x on one input line
    // Bytes are packed low first
    function automatic int pixel_sum(input int line, input int x, input int wpl);
        int        sum;
        int        b;
        mem_word_t word;
        sum = 0;
        for (int c = 0; c < 3; c++) begin
            b    = 3 * x + c;
            word = mem[line * wpl + b / 4];
            sum  = sum + int'(word[8 * (b % 4) +: 8]);
        end
        return sum;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        mismatch_cnt++;
        $display("ERROR %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_order(input string what);
        order_cnt++;
        $display("Sequence error: %s", what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory contents and expected traffic for one run

    task automatic load_run(input int w, input int h, input int k);
        int      wpl;
        int      sum;
        wr_exp_t entry;
        wpl = w * 3 / 4;
        for (int i = 0; i < 64; i++) begin
            lcg_state = lcg_next(lcg_state);
            mem[i]    = lcg_state;
        end
        rd_q.delete();
        wr_q.delete();
        for (int r = 0; r <= h - k; r++) begin
            for (int kk = 0; kk < k; kk++) begin
                for (int wd = 0; wd < wpl; wd++) begin
                    rd_q.push_back(word_addr_t'(((r + kk) * wpl + wd) << ADDR_MODE));
                end
            end
            for (int x = 0; x < w; x++) begin
                sum = 0;
                for (int kk = 0; kk < k; kk++) begin
                    sum = sum + pixel_sum(r + kk, x, wpl);
                end
                entry.bank = 2'((r % 2) + 1);
                entry.addr = word_addr_t'(x << ADDR_MODE);
                entry.data = mem_word_t'(sum);
                wr_q.push_back(entry);
            end
        end
    endtask

    task automatic do_run(input int w, input int h, input int k, input int run_no);
        load_run(w, h, k);
        @(posedge clk);
        #1;
        i_conf_width    = dim_t'(w);
        i_conf_height   = dim_t'(h);
        i_conf_kernel_h = dim_t'(k);
        @(posedge clk);
        #1 i_start = 1'b1;
        @(posedge clk);
        #1 i_start = 1'b0;
        while (!o_done) @(negedge clk);
        repeat (3) @(posedge clk);
        assert (rd_q.size() == 0) else report_order("reads missing from the input map walk");
        assert (done_cnt == run_no) else report_order("done did not pulse exactly once");
    endtask

    // Input BRAM model answering one cycle after enable
    initial begin
        i_mem_odat_0 = '0;
        forever begin
            @(negedge clk);
            if (o_mem_enb_0) begin
                mem_idx = o_mem_addr_0[7:2];
                @(posedge clk);
                #1 i_mem_odat_0 = mem[mem_idx];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read order, output writes and done timing

    always @(negedge clk) begin
        cyc++;
        if (o_mem_enb_0) begin
            assert (o_mem_rst_0 == 1'b0)
                else show_mismatch("o_mem_rst_0", 32'd0, 32'(o_mem_rst_0));
            assert (rd_q.size() != 0) else report_order("read issued past the end of the map");
            if (rd_q.size() != 0) begin
                exp_rd = rd_q.pop_front();
                assert (o_mem_addr_0 == exp_rd)
                    else show_mismatch("o_mem_addr_0", exp_rd, o_mem_addr_0);
            end
        end
        if (o_mem_enb_1 || o_mem_enb_2) begin
            port     = o_mem_enb_1 ? 1 : 2;
            act_addr = o_mem_enb_1 ? o_mem_addr_1 : o_mem_addr_2;
            act_dat  = o_mem_enb_1 ? o_mem_idat_1 : o_mem_idat_2;
            act_wren = o_mem_enb_1 ? o_mem_wren_1 : o_mem_wren_2;
            assert (wr_q.size() != 0) else report_order("output write with no result left");
            if (wr_q.size() != 0) begin
                exp_wr = wr_q.pop_front();
                assert (port == int'(exp_wr.bank))
                    else show_mismatch($sformatf("o_mem_enb_%0d", exp_wr.bank), 32'd1, 32'd0);
                assert (act_addr == exp_wr.addr)
                    else show_mismatch($sformatf("o_mem_addr_%0d", port), exp_wr.addr, act_addr);
                assert (act_dat == exp_wr.data)
                    else show_mismatch($sformatf("o_mem_idat_%0d", port), exp_wr.data, act_dat);
                assert (act_wren == {NUM_BYTE{1'b1}})
                    else show_mismatch($sformatf("o_mem_wren_%0d", port), 32'hf, 32'(act_wren));
                if (wr_q.size() == 0) begin
                    last_wr_cyc = cyc;
                end
            end
        end
        if (o_done) begin
            done_cnt++;
            assert (cyc == last_wr_cyc + 1)
                else report_order("done not one cycle after last write");
            assert (wr_q.size() == 0)
                else report_order("done raised with results still missing");
        end
    end

    initial begin
        int limit;
        limit = 4 * (run_words(8, 6, 3) + run_words(4, 3, 1)) + 200;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the runs finished", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        i_arst_n        = 1'b0;
        i_start         = 1'b0;
        i_conf_width    = '0;
        i_conf_height   = '0;
        i_conf_kernel_h = '0;
        lcg_state       = 32'd92;
        repeat (16) @(posedge clk);
        #1 i_arst_n = 1'b1;
        repeat (4) @(posedge clk);
        do_run(8, 6, 3, 1);
        // Restart with a narrow map and single-line rows
        do_run(4, 3, 1, 2);
        props_fails = dut_i.props_i.fail_total;
        $display("Errors: %0d value mismatches, %0d sequence errors, %0d assertion failures",
                 mismatch_cnt, order_cnt, props_fails);
        if (mismatch_cnt + order_cnt + props_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== bench/dnn_accelerator_core_props.sv ====
`timescale 1ns/100ps

module dnn_accelerator_core_props (
    input  logic                             clk,
    input  logic                             i_arst_n,
    input  logic                             i_start,
    input  logic                             i_busy,
    input  logic                             i_done,
    input  logic                             i_rd_enb,
    input  logic                             i_wr_enb_1,
    input  logic                             i_wr_enb_2,
    input  logic [dnn_mem_pkg::NUM_BYTE-1:0] i_wren_1,
    input  logic [dnn_mem_pkg::NUM_BYTE-1:0] i_wren_2
);

    logic started_q;
    logic outputs_quiet;
    int   idle_fail    = 0;
    int   overlap_fail = 0;
    int   start_fail   = 0;
    int   hold_fail    = 0;
    int   end_fail     = 0;
    int   fail_total;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            started_q <= 1'b0;
        end else if (i_start) begin
            started_q <= 1'b1;
        end
    end

    assign outputs_quiet = !(i_busy || i_done || i_rd_enb || i_wr_enb_1 || i_wr_enb_2 ||
                             (|i_wren_1) || (|i_wren_2));
    assign fail_total    = idle_fail + overlap_fail + start_fail + hold_fail + end_fail;

    //////////////////////////////////////////////////////////////////////
    // Status and bank properties

    idle_before_start: assert property (@(posedge clk)
        (i_arst_n && !started_q) |-> outputs_quiet)
        else begin
            idle_fail++;
            $error("core active after reset before the first start");
        end

    banks_exclusive: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_wr_enb_1 && i_wr_enb_2))
        else begin
            overlap_fail++;
            $error("both output banks written in one cycle");
        end

    busy_after_start: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_start |=> i_busy)
        else begin
            start_fail++;
            $error("busy not raised the cycle after start");
        end

    busy_until_done: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_busy && !i_done) |=> i_busy)
        else begin
            hold_fail++;
            $error("busy dropped before done");
        end

    // Done is a single pulse and busy falls with it
    done_ends_run: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_done |=> (!i_done && !i_busy))
        else begin
            end_fail++;
            $error("done not a single pulse ending busy");
        end

endmodule

// ==== verilog/dnn_accelerator_core.sv ====
`timescale 1ns/100ps

module dnn_accelerator_core (
    input  logic                               clk,
    input  logic                               i_arst_n,
    input  logic                               i_start,
    input  dnn_geom_pkg::dim_t                 i_conf_width,
    input  dnn_geom_pkg::dim_t                 i_conf_height,
    input  dnn_geom_pkg::dim_t                 i_conf_kernel_h,

    output logic [dnn_mem_pkg::ADDR_WIDTH-1:0] o_mem_addr_0,
    output logic                               o_mem_enb_0,
    output logic                               o_mem_rst_0,
    input  dnn_mem_pkg::mem_word_t             i_mem_odat_0,

    output logic [dnn_mem_pkg::ADDR_WIDTH-1:0] o_mem_addr_1,
    output dnn_mem_pkg::mem_word_t             o_mem_idat_1,
    output logic [dnn_mem_pkg::NUM_BYTE-1:0]   o_mem_wren_1,
    output logic                               o_mem_enb_1,

    output logic [dnn_mem_pkg::ADDR_WIDTH-1:0] o_mem_addr_2,
    output dnn_mem_pkg::mem_word_t             o_mem_idat_2,
    output logic [dnn_mem_pkg::NUM_BYTE-1:0]   o_mem_wren_2,
    output logic                               o_mem_enb_2,

    output logic                               o_busy,
    output logic                               o_done
);

    import dnn_geom_pkg::*;
    import dnn_mem_pkg::*;

    logic       datareq_rden;
    word_addr_t datareq_addr;
    logic       concat_stall;
    mem_word_t  rdctrl_odat;
    logic       rdctrl_oval;
    pixel_t     concat_pixel;
    logic       concat_pval;
    psum_t      accum_psum;
    logic       accum_vld;
    logic       accum_row_last;
    logic       writer_done;

    //////////////////////////////////////////////////////////////////////
    // Input side

    data_req data_req_inst (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_start         (i_start),
        .i_stall         (concat_stall),
        .i_done          (writer_done),
        .i_conf_width    (i_conf_width),
        .i_conf_height   (i_conf_height),
        .i_conf_kernel_h (i_conf_kernel_h),
        .o_rden          (datareq_rden),
        .o_addr          (datareq_addr),
        .o_busy          (o_busy)
    );

    bram_rd_ctrl #(
        .MEM_DELAY (MEM_DELAY)
    ) data_bram_ctrl_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rden     (datareq_rden),
        .i_addr     (datareq_addr),
        .i_mem_odat (i_mem_odat_0),
        .o_mem_addr (o_mem_addr_0),
        .o_mem_enb  (o_mem_enb_0),
        .o_mem_rst  (o_mem_rst_0),
        .o_odat     (rdctrl_odat),
        .o_oval     (rdctrl_oval)
    );

    //////////////////////////////////////////////////////////////////////
    // Processing

    pixel_concat pixel_concat_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_idat   (rdctrl_odat),
        .i_ival   (rdctrl_oval),
        .o_pixel  (concat_pixel),
        .o_pval   (concat_pval),
        .o_stall  (concat_stall)
    );

    line_psum_accum line_psum_accum_inst (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_start         (i_start),
        .i_pixel         (concat_pixel),
        .i_pval          (concat_pval),
        .i_conf_width    (i_conf_width),
        .i_conf_kernel_h (i_conf_kernel_h),
        .o_psum          (accum_psum),
        .o_psum_vld      (accum_vld),
        .o_row_last      (accum_row_last)
    );

    //////////////////////////////////////////////////////////////////////
    // Output side, ping-pong banks

    psum_bank_writer psum_bank_writer_inst (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_start         (i_start),
        .i_psum          (accum_psum),
        .i_psum_vld      (accum_vld),
        .i_row_last      (accum_row_last),
        .i_conf_height   (i_conf_height),
        .i_conf_kernel_h (i_conf_kernel_h),
        .o_mem_addr_1    (o_mem_addr_1),
        .o_mem_idat_1    (o_mem_idat_1),
        .o_mem_wren_1    (o_mem_wren_1),
        .o_mem_enb_1     (o_mem_enb_1),
        .o_mem_addr_2    (o_mem_addr_2),
        .o_mem_idat_2    (o_mem_idat_2),
        .o_mem_wren_2    (o_mem_wren_2),
        .o_mem_enb_2     (o_mem_enb_2),
        .o_done          (writer_done)
    );

    assign o_done = writer_done;

endmodule

// ==== verilog/psum_bank_writer.sv ====
`timescale 1ns/100ps

module psum_bank_writer (
    input  logic                               clk,
    input  logic                               i_arst_n,
    input  logic                               i_start,
    input  dnn_geom_pkg::psum_t                i_psum,
    input  logic                               i_psum_vld,
    input  logic                               i_row_last,
    input  dnn_geom_pkg::dim_t                 i_conf_height,
    input  dnn_geom_pkg::dim_t                 i_conf_kernel_h,
    output logic [dnn_mem_pkg::ADDR_WIDTH-1:0] o_mem_addr_1,
    output dnn_mem_pkg::mem_word_t             o_mem_idat_1,
    output logic [dnn_mem_pkg::NUM_BYTE-1:0]   o_mem_wren_1,
    output logic                               o_mem_enb_1,
    output logic [dnn_mem_pkg::ADDR_WIDTH-1:0] o_mem_addr_2,
    output dnn_mem_pkg::mem_word_t             o_mem_idat_2,
    output logic [dnn_mem_pkg::NUM_BYTE-1:0]   o_mem_wren_2,
    output logic                               o_mem_enb_2,
    output logic                               o_done
);

    import dnn_geom_pkg::*;
    import dnn_mem_pkg::*;

    dim_t       x_cnt;
    dim_t       rows_done;
    dim_t       last_row;
    logic       bank_q;
    logic       last_q;
    logic       wr_1_q;
    logic       wr_2_q;
    word_addr_t wr_addr_q;
    mem_word_t  wr_dat_q;

    assign last_row = i_conf_height - i_conf_kernel_h;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_cnt     <= '0;
            rows_done <= '0;
            bank_q    <= 1'b0;
            last_q    <= 1'b0;
            wr_1_q    <= 1'b0;
            wr_2_q    <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            // Even rows to bank 1, odd rows to bank 2
            wr_1_q <= i_psum_vld && !bank_q;
            wr_2_q <= i_psum_vld && bank_q;
            last_q <= i_psum_vld && i_row_last && (rows_done == last_row);
            o_done <= last_q;
            if (i_start) begin
                x_cnt     <= '0;
                rows_done <= '0;
                bank_q    <= 1'b0;
            end else if (i_psum_vld) begin
                if (i_row_last) begin
                    x_cnt     <= '0;
                    bank_q    <= ~bank_q;
                    rows_done <= rows_done + dim_t'(1);
                end else begin
                    x_cnt <= x_cnt + dim_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_psum_vld) begin
            wr_addr_q <= word_addr_t'(x_cnt) << ADDR_MODE;
            wr_dat_q  <= mem_word_t'(i_psum);
        end
    end

    assign o_mem_addr_1 = wr_addr_q;
    assign o_mem_idat_1 = wr_dat_q;
    assign o_mem_wren_1 = {NUM_BYTE{wr_1_q}};
    assign o_mem_enb_1  = wr_1_q;

    assign o_mem_addr_2 = wr_addr_q;
    assign o_mem_idat_2 = wr_dat_q;
    assign o_mem_wren_2 = {NUM_BYTE{wr_2_q}};
    assign o_mem_enb_2  = wr_2_q;

endmodule

// ==== verilog/line_psum_accum.sv ====
`timescale 1ns/100ps

module line_psum_accum (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_start,
    input  dnn_geom_pkg::pixel_t i_pixel,
    input  logic                 i_pval,
    input  dnn_geom_pkg::dim_t   i_conf_width,
    input  dnn_geom_pkg::dim_t   i_conf_kernel_h,
    output dnn_geom_pkg::psum_t  o_psum,
    output logic                 o_psum_vld,
    output logic                 o_row_last
);

    import dnn_geom_pkg::*;

    psum_t row_buf [MAX_WIDTH];
    dim_t  col_cnt;
    dim_t  kline_cnt;
    psum_t chan_sum;
    psum_t acc;
    logic  col_end;
    logic  kline_last;

    // Channel sum of the incoming pixel
    always_comb begin
        chan_sum = '0;
        for (int c = 0; c < NUM_CHANNEL; c++) begin
            chan_sum = chan_sum + psum_t'(i_pixel[c*BIT_WIDTH +: BIT_WIDTH]);
        end
    end

    // First kernel line overwrites the row buffer
    assign acc = (kline_cnt == '0) ? chan_sum
                                   : row_buf[col_cnt[COL_BITS-1:0]] + chan_sum;

    assign col_end    = (col_cnt == i_conf_width - dim_t'(1));
    assign kline_last = (kline_cnt == i_conf_kernel_h - dim_t'(1));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            col_cnt    <= '0;
            kline_cnt  <= '0;
            o_psum_vld <= 1'b0;
            o_row_last <= 1'b0;
        end else begin
            o_psum_vld <= i_pval && kline_last;
            o_row_last <= i_pval && kline_last && col_end;
            if (i_start) begin
                col_cnt   <= '0;
                kline_cnt <= '0;
            end else if (i_pval) begin
                if (col_end) begin
                    col_cnt   <= '0;
                    kline_cnt <= kline_last ? '0 : kline_cnt + dim_t'(1);
                end else begin
                    col_cnt <= col_cnt + dim_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_pval) begin
            row_buf[col_cnt[COL_BITS-1:0]] <= acc;
            o_psum                         <= acc;
        end
    end

endmodule

// ==== verilog/pixel_concat.sv ====
`timescale 1ns/100ps

module pixel_concat (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  dnn_mem_pkg::mem_word_t i_idat,
    input  logic                   i_ival,
    output dnn_geom_pkg::pixel_t   o_pixel,
    output logic                   o_pval,
    output logic                   o_stall
);

    import dnn_geom_pkg::*;
    import dnn_mem_pkg::*;

    typedef logic [8*CONCAT_BYTES-1:0]          buf_t;
    typedef logic [$clog2(CONCAT_BYTES+1)-1:0]  fill_t;

    buf_t  buf_q;
    buf_t  shifted;
    buf_t  keep_mask;
    buf_t  buf_d;
    fill_t fill_q;
    fill_t fill_rem;
    fill_t fill_d;
    logic  take;

    //////////////////////////////////////////////////////////////////////
    // Byte queue, oldest byte at bit 0

    always_comb begin
        take     = (fill_q >= fill_t'(NUM_CHANNEL));
        shifted  = take ? (buf_q >> PIXEL_WIDTH) : buf_q;
        fill_rem = take ? (fill_q - fill_t'(NUM_CHANNEL)) : fill_q;
        // Clear everything above the valid bytes
        keep_mask = ~({(8*CONCAT_BYTES){1'b1}} << {fill_rem, 3'b000});
        buf_d     = shifted & keep_mask;
        fill_d    = fill_rem;
        if (i_ival) begin
            buf_d  = buf_d | (buf_t'(i_idat) << {fill_rem, 3'b000});
            fill_d = fill_rem + fill_t'(NUM_BYTE);
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fill_q <= '0;
            o_pval <= 1'b0;
        end else begin
            fill_q <= fill_d;
            o_pval <= take;
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_d;
        if (take) begin
            o_pixel <= buf_q[PIXEL_WIDTH-1:0];
        end
    end

    // Leaves room for words already in flight
    assign o_stall = (fill_q > fill_t'(STALL_FILL));

endmodule

// ==== verilog/bram_rd_ctrl.sv ====
`timescale 1ns/100ps

module bram_rd_ctrl #(
    parameter int MEM_DELAY = dnn_mem_pkg::MEM_DELAY
) (
    input  logic                               clk,
    input  logic                               i_arst_n,
    input  logic                               i_rden,
    input  dnn_mem_pkg::word_addr_t            i_addr,
    input  dnn_mem_pkg::mem_word_t             i_mem_odat,
    output logic [dnn_mem_pkg::ADDR_WIDTH-1:0] o_mem_addr,
    output logic                               o_mem_enb,
    output logic                               o_mem_rst,
    output dnn_mem_pkg::mem_word_t             o_odat,
    output logic                               o_oval
);

    import dnn_mem_pkg::*;

    // One bit per cycle of read latency
    logic [MEM_DELAY-1:0] vld_sr;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_enb <= 1'b0;
            vld_sr    <= '0;
        end else begin
            o_mem_enb <= i_rden;
            vld_sr[0] <= o_mem_enb;
            for (int i = 1; i < MEM_DELAY; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    // BRAM takes byte addresses
    always_ff @(posedge clk) begin
        if (i_rden) begin
            o_mem_addr <= i_addr << ADDR_MODE;
        end
    end

    assign o_mem_rst = ~i_arst_n;
    assign o_odat    = i_mem_odat;
    assign o_oval    = vld_sr[MEM_DELAY-1];

endmodule

// ==== verilog/data_req.sv ====
`timescale 1ns/100ps

module data_req (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_start,
    input  logic                    i_stall,
    input  logic                    i_done,
    input  dnn_geom_pkg::dim_t      i_conf_width,
    input  dnn_geom_pkg::dim_t      i_conf_height,
    input  dnn_geom_pkg::dim_t      i_conf_kernel_h,
    output logic                    o_rden,
    output dnn_mem_pkg::word_addr_t o_addr,
    output logic                    o_busy
);

    import dnn_geom_pkg::*;
    import dnn_mem_pkg::*;

    logic [7:0] width_x3;
    dim_t       words_per_line;
    dim_t       last_row;
    word_addr_t wpl_ext;

    logic       req_act_q;
    logic       run_q;
    dim_t       word_cnt;
    dim_t       line_cnt;
    dim_t       row_cnt;
    word_addr_t row_base;
    word_addr_t line_base;

    logic       word_end;
    logic       line_end;
    logic       row_end;

    // 3 bytes per pixel packed into 4-byte words
    assign width_x3       = {2'b00, i_conf_width} + {1'b0, i_conf_width, 1'b0};
    assign words_per_line = width_x3[7:2];
    assign last_row       = i_conf_height - i_conf_kernel_h;
    assign wpl_ext        = word_addr_t'(words_per_line);

    assign word_end = (word_cnt == words_per_line - dim_t'(1));
    assign line_end = (line_cnt == i_conf_kernel_h - dim_t'(1));
    assign row_end  = (row_cnt == last_row);

    //////////////////////////////////////////////////////////////////////
    // Row / kernel line / word walk

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_act_q <= 1'b0;
            run_q     <= 1'b0;
            word_cnt  <= '0;
            line_cnt  <= '0;
            row_cnt   <= '0;
            row_base  <= '0;
            line_base <= '0;
        end else if (i_start) begin
            req_act_q <= 1'b1;
            run_q     <= 1'b1;
            word_cnt  <= '0;
            line_cnt  <= '0;
            row_cnt   <= '0;
            row_base  <= '0;
            line_base <= '0;
        end else begin
            // Held past the last read until the final bank write
            if (i_done) begin
                run_q <= 1'b0;
            end
            if (o_rden) begin
                if (!word_end) begin
                    word_cnt <= word_cnt + dim_t'(1);
                end else begin
                    word_cnt <= '0;
                    if (!line_end) begin
                        line_cnt  <= line_cnt + dim_t'(1);
                        line_base <= line_base + wpl_ext;
                    end else begin
                        // Next output row starts one input line lower
                        line_cnt  <= '0;
                        row_cnt   <= row_cnt + dim_t'(1);
                        row_base  <= row_base + wpl_ext;
                        line_base <= row_base + wpl_ext;
                        if (row_end) begin
                            req_act_q <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    assign o_rden = req_act_q && !i_stall;
    assign o_addr = line_base + word_addr_t'(word_cnt);
    assign o_busy = run_q;

endmodule

// ==== verilog/dnn_mem_pkg.sv ====
package dnn_mem_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int NUM_BYTE   = DATA_WIDTH / 8;

    // Word address to byte address shift
    localparam int ADDR_MODE  = 2;

    // BRAM read latency in cycles
    localparam int MEM_DELAY  = 1;

    // Unpack buffer depth and the fill level above which reads pause
    localparam int CONCAT_BYTES = 16;
    localparam int STALL_FILL   = CONCAT_BYTES - NUM_BYTE * (MEM_DELAY + 2);

    typedef logic [ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [DATA_WIDTH-1:0] mem_word_t;

endpackage

// ==== verilog/dnn_geom_pkg.sv ====
package dnn_geom_pkg;

    // Pixel layout, one byte per channel
    localparam int BIT_WIDTH   = 8;
    localparam int NUM_CHANNEL = 3;
    localparam int PIXEL_WIDTH = BIT_WIDTH * NUM_CHANNEL;

    // Channel 0 in the lowest byte
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // Holds 7 kernel lines of full-scale channel sums
    localparam int PSUM_WIDTH = 16;
    typedef logic [PSUM_WIDTH-1:0] psum_t;

    // Map size limits
    localparam int MAX_WIDTH  = 32;
    localparam int MAX_KERNEL = 7;
    localparam int DIM_WIDTH  = 6;
    localparam int COL_BITS   = $clog2(MAX_WIDTH);

    // Width, height, row, column and kernel-line counts
    typedef logic [DIM_WIDTH-1:0] dim_t;

endpackage
